/* logic/decode_pkg.sv */
package decode_pkg;

    ////////////////////
    // Execution units behind the decode stage

    // The ALU also receives branches, memory ops and
    // anything the decoder flags as illegal
    typedef enum logic {
        unit_alu = 1'b0,
        unit_mul = 1'b1
    } exec_unit_t;

    ////////////////////
    // Reorder buffer tickets

    // Default ticket width, 16 instructions in flight
    localparam int DEFAULT_ROB_ID_WIDTH = 4;

endpackage

/* logic/decode_stage.sv */
module decode_stage
    import isa_pkg::*;
    import decode_pkg::*;
#(
    parameter int ROB_ID_WIDTH = DEFAULT_ROB_ID_WIDTH
)
(
    input  logic                      clock,
    input  logic                      rst_n,

    // Fetch
    input  logic                      fetch_valid,
    output logic                      fetch_ready,
    input  logic [INSTR_WIDTH-1:0]    fetch_instr,
    input  logic [DATA_WIDTH-1:0]     fetch_pc,

    // Write-back
    input  logic                      wb_valid,
    input  logic [REG_ADDR_WIDTH-1:0] wb_addr,
    input  logic [DATA_WIDTH-1:0]     wb_data,
    input  logic [ROB_ID_WIDTH-1:0]   wb_rob_id,

    // Issue payload, shared by both units
    output opcode_t                   issue_opcode,
    output logic [REG_ADDR_WIDTH-1:0] issue_rd,
    output logic [DATA_WIDTH-1:0]     issue_pc,
    output logic [ROB_ID_WIDTH-1:0]   issue_rob_id,
    output logic [DATA_WIDTH-1:0]     issue_ra_data,
    output logic [DATA_WIDTH-1:0]     issue_rb_data,
    output logic [DATA_WIDTH-1:0]     issue_offset,
    output logic [ROB_ID_WIDTH-1:0]   issue_ticket_src1,
    output logic                      issue_blocks_src1,
    output logic [ROB_ID_WIDTH-1:0]   issue_ticket_src2,
    output logic                      issue_blocks_src2,
    output logic                      issue_illegal,

    // Per unit handshake
    output logic                      alu_valid,
    input  logic                      alu_ready,
    output logic                      mul_valid,
    input  logic                      mul_ready
);

    opcode_t                   dec_opcode;
    logic [REG_ADDR_WIDTH-1:0] dec_rd;
    logic [REG_ADDR_WIDTH-1:0] dec_ra;
    logic [REG_ADDR_WIDTH-1:0] dec_rb;
    logic [DATA_WIDTH-1:0]     dec_offset;
    logic                      dec_uses_src1;
    logic                      dec_uses_src2;
    logic                      dec_writes_rd;
    logic                      dec_illegal;
    exec_unit_t                dec_unit;

    logic [DATA_WIDTH-1:0]     rf_src1_data;
    logic [DATA_WIDTH-1:0]     rf_src2_data;

    logic [ROB_ID_WIDTH-1:0]   sb_rob_id;
    logic [ROB_ID_WIDTH-1:0]   sb_ticket_src1;
    logic [ROB_ID_WIDTH-1:0]   sb_ticket_src2;
    logic                      sb_blocks_src1;
    logic                      sb_blocks_src2;

    logic                      out_valid;
    exec_unit_t                out_unit;
    logic                      drain;
    logic                      accept;

    rf_write_if #(
        .ROB_ID_WIDTH (ROB_ID_WIDTH),
        .ADDR_WIDTH   (REG_ADDR_WIDTH),
        .DATA_WIDTH   (DATA_WIDTH)
    ) wb_bus ();

    assign wb_bus.valid  = wb_valid;
    assign wb_bus.addr   = wb_addr;
    assign wb_bus.data   = wb_data;
    assign wb_bus.rob_id = wb_rob_id;

    ////////////////////
    // Decode, register read and scoreboard lookup

    instr_decoder u_instr_decoder (
        .instr     (fetch_instr),
        .opcode    (dec_opcode),
        .rd_addr   (dec_rd),
        .ra_addr   (dec_ra),
        .rb_addr   (dec_rb),
        .offset    (dec_offset),
        .uses_src1 (dec_uses_src1),
        .uses_src2 (dec_uses_src2),
        .writes_rd (dec_writes_rd),
        .illegal   (dec_illegal),
        .unit      (dec_unit)
    );

    reg_file u_reg_file (
        .clock     (clock),
        .rst_n     (rst_n),
        .src1_addr (dec_ra),
        .src2_addr (dec_rb),
        .src1_data (rf_src1_data),
        .src2_data (rf_src2_data),
        .wb        (wb_bus)
    );

    scoreboard #(
        .ROB_ID_WIDTH (ROB_ID_WIDTH)
    ) u_scoreboard (
        .clock       (clock),
        .rst_n       (rst_n),
        .accept      (accept),
        .src1_addr   (dec_ra),
        .src2_addr   (dec_rb),
        .rd_addr     (dec_rd),
        .uses_src1   (dec_uses_src1),
        .uses_src2   (dec_uses_src2),
        .writes_rd   (dec_writes_rd),
        .rob_id      (sb_rob_id),
        .ticket_src1 (sb_ticket_src1),
        .ticket_src2 (sb_ticket_src2),
        .blocks_src1 (sb_blocks_src1),
        .blocks_src2 (sb_blocks_src2),
        .wb          (wb_bus)
    );

    ////////////////////
    // Handshake

    // The entry leaves when the unit it targets takes it
    assign drain       = out_valid && ((out_unit == unit_mul) ? mul_ready : alu_ready);
    assign fetch_ready = !out_valid || drain;
    assign accept      = fetch_valid && fetch_ready;

    assign alu_valid = out_valid && (out_unit == unit_alu);
    assign mul_valid = out_valid && (out_unit == unit_mul);

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            out_unit  <= unit_alu;
        end
        else if (accept)
        begin
            out_valid <= 1'b1;
            out_unit  <= dec_unit;
        end
        else if (drain)
        begin
            out_valid <= 1'b0;
        end
    end

    ////////////////////
    // Output register

    always_ff @(posedge clock)
    begin
        if (accept)
        begin
            issue_opcode      <= dec_opcode;
            issue_rd          <= dec_rd;
            issue_pc          <= fetch_pc;
            issue_rob_id      <= sb_rob_id;
            issue_ra_data     <= rf_src1_data;
            issue_rb_data     <= rf_src2_data;
            issue_offset      <= dec_offset;
            issue_ticket_src1 <= sb_ticket_src1;
            issue_blocks_src1 <= sb_blocks_src1;
            issue_ticket_src2 <= sb_ticket_src2;
            issue_blocks_src2 <= sb_blocks_src2;
            issue_illegal     <= dec_illegal;
        end
    end

    // A stalled entry keeps its unit and payload until it drains
    a_hold_payload: assert property (@(posedge clock) disable iff (!rst_n)
        (out_valid && !drain) |=> out_valid && $stable({out_unit, issue_opcode, issue_rd,
            issue_pc, issue_rob_id, issue_ra_data, issue_rb_data, issue_offset,
            issue_ticket_src1, issue_blocks_src1, issue_ticket_src2, issue_blocks_src2,
            issue_illegal}))
        else $error("issue payload changed while stalled");

    a_one_unit: assert property (@(posedge clock) disable iff (!rst_n) !(alu_valid && mul_valid))
        else $error("ALU and MUL valid at the same time");

endmodule

/* logic/instr_decoder.sv */
module instr_decoder
    import isa_pkg::*;
    import decode_pkg::*;
(
    input  logic [INSTR_WIDTH-1:0]    instr,
    output opcode_t                   opcode,
    output logic [REG_ADDR_WIDTH-1:0] rd_addr,
    output logic [REG_ADDR_WIDTH-1:0] ra_addr,
    output logic [REG_ADDR_WIDTH-1:0] rb_addr,
    output logic [DATA_WIDTH-1:0]     offset,
    output logic                      uses_src1,
    output logic                      uses_src2,
    output logic                      writes_rd,
    output logic                      illegal,
    output exec_unit_t                unit
);

    ////////////////////
    // Field extraction

    assign opcode  = opcode_t'(instr[OPCODE_MSB:OPCODE_LSB]);
    assign rd_addr = instr[RD_MSB:RD_LSB];
    assign ra_addr = instr[RA_MSB:RA_LSB];

    // Zero-extended immediate
    assign offset = {{(DATA_WIDTH-OFFSET_WIDTH){1'b0}}, instr[OFFSET_MSB:OFFSET_LSB]};

    ////////////////////
    // Opcode classification

    // rb_addr is the second source register, which for a store
    // is the data register held in the rd field
    always_comb
    begin
        uses_src1 = 1'b0;
        uses_src2 = 1'b0;
        writes_rd = 1'b0;
        illegal   = 1'b0;
        unit      = unit_alu;
        rb_addr   = instr[RB_MSB:RB_LSB];

        case (opcode)
            op_add, op_sub, op_and:
            begin
                uses_src1 = 1'b1;
                uses_src2 = 1'b1;
                writes_rd = 1'b1;
            end
            op_mul:
            begin
                uses_src1 = 1'b1;
                uses_src2 = 1'b1;
                writes_rd = 1'b1;
                unit      = unit_mul;
            end
            op_addi, op_ldw:
            begin
                uses_src1 = 1'b1;
                writes_rd = 1'b1;
            end
            op_stw:
            begin
                uses_src1 = 1'b1;
                uses_src2 = 1'b1;
                rb_addr   = instr[RD_MSB:RD_LSB];
            end
            op_beq:
            begin
                uses_src1 = 1'b1;
                uses_src2 = 1'b1;
            end
            op_jump, op_nop:
            begin
                // No register operands
            end
            default:
            begin
                // Undefined opcode, no operands, sent to the ALU
                illegal = 1'b1;
            end
        endcase
    end

endmodule

/* logic/isa_pkg.sv */
package isa_pkg;

    ////////////////////
    // Widths and sizes

    localparam int INSTR_WIDTH    = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int DATA_WIDTH     = 32;
    localparam int NUM_REGS       = 32;
    localparam int OFFSET_WIDTH   = 15;
    localparam int OPCODE_WIDTH   = 7;

    ////////////////////
    // Field positions inside the instruction word

    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 25;
    localparam int RD_MSB     = 24;
    localparam int RD_LSB     = 20;
    localparam int RA_MSB     = 19;
    localparam int RA_LSB     = 15;
    localparam int RB_MSB     = 14;
    localparam int RB_LSB     = 10;
    // Offset overlaps rb, the opcode decides which one is meant
    localparam int OFFSET_MSB = 14;
    localparam int OFFSET_LSB = 0;

    ////////////////////
    // Opcodes

    typedef enum logic [OPCODE_WIDTH-1:0] {
        op_add  = 7'd0,
        op_sub  = 7'd1,
        op_and  = 7'd2,
        op_mul  = 7'd3,
        op_addi = 7'd4,
        // Memory
        op_ldw  = 7'd16,
        op_stw  = 7'd17,
        // Control flow
        op_beq  = 7'd48,
        op_jump = 7'd49,
        op_nop  = 7'd127
    } opcode_t;

endpackage

/* logic/reg_file.sv */
module reg_file
    import isa_pkg::*;
(
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic [REG_ADDR_WIDTH-1:0] src1_addr,
    input  logic [REG_ADDR_WIDTH-1:0] src2_addr,
    output logic [DATA_WIDTH-1:0]     src1_data,
    output logic [DATA_WIDTH-1:0]     src2_data,
    rf_write_if.sink                  wb
);

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    ////////////////////
    // Write port

    // Register 0 is hardwired, writes to it are dropped
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.valid && (wb.addr != '0))
        begin
            regs[wb.addr] <= wb.data;
        end
    end

    ////////////////////
    // Read ports

    // A write in the same cycle is forwarded to the reader
    function automatic logic [DATA_WIDTH-1:0] read_port(input logic [REG_ADDR_WIDTH-1:0] addr);
        if (addr == '0)
            return '0;
        else if (wb.valid && (wb.addr == addr))
            return wb.data;
        else
            return regs[addr];
    endfunction

    assign src1_data = read_port(src1_addr);
    assign src2_data = read_port(src2_addr);

endmodule

/* logic/rf_write_if.sv */
interface rf_write_if #(
    parameter int ROB_ID_WIDTH = 4,
    parameter int ADDR_WIDTH   = 5,
    parameter int DATA_WIDTH   = 32
);

    // Write-back port of the register file
    logic                    valid;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   data;
    // Ticket of the instruction that produced the data
    logic [ROB_ID_WIDTH-1:0] rob_id;

    modport source (output valid, output addr, output data, output rob_id);

    modport sink (input valid, input addr, input data, input rob_id);

endinterface

/* logic/scoreboard.sv */
module scoreboard
    import isa_pkg::*;
#(
    parameter int ROB_ID_WIDTH = 4
)
(
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      accept,
    input  logic [REG_ADDR_WIDTH-1:0] src1_addr,
    input  logic [REG_ADDR_WIDTH-1:0] src2_addr,
    input  logic [REG_ADDR_WIDTH-1:0] rd_addr,
    input  logic                      uses_src1,
    input  logic                      uses_src2,
    input  logic                      writes_rd,
    output logic [ROB_ID_WIDTH-1:0]   rob_id,
    output logic [ROB_ID_WIDTH-1:0]   ticket_src1,
    output logic [ROB_ID_WIDTH-1:0]   ticket_src2,
    output logic                      blocks_src1,
    output logic                      blocks_src2,
    rf_write_if.sink                  wb
);

    // Per register: an older instruction still has to write it
    logic [NUM_REGS-1:0]     owner_valid;
    logic [ROB_ID_WIDTH-1:0] owner_id [NUM_REGS];
    logic [ROB_ID_WIDTH-1:0] tail;

    // Write-back from the instruction that owns the register
    logic wb_release;

    assign wb_release = wb.valid && owner_valid[wb.addr] && (owner_id[wb.addr] == wb.rob_id);

    ////////////////////
    // Lookup for the instruction in decode

    assign rob_id      = tail;
    assign ticket_src1 = owner_id[src1_addr];
    assign ticket_src2 = owner_id[src2_addr];

    // An owner released on this very edge no longer blocks
    assign blocks_src1 = uses_src1 && owner_valid[src1_addr] &&
                         !(wb_release && (wb.addr == src1_addr));
    assign blocks_src2 = uses_src2 && owner_valid[src2_addr] &&
                         !(wb_release && (wb.addr == src2_addr));

    ////////////////////
    // Owner and tail update

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tail        <= '0;
            owner_valid <= '0;
            for (int i = 0; i < NUM_REGS; i++)
            begin
                owner_id[i] <= '0;
            end
        end
        else
        begin
            if (wb_release)
                owner_valid[wb.addr] <= 1'b0;
            // Comes second so a new owner overrides a release
            if (accept && writes_rd && (rd_addr != '0))
            begin
                owner_valid[rd_addr] <= 1'b1;
                owner_id[rd_addr]    <= tail;
            end
            if (accept)
                tail <= tail + 1'b1;
        end
    end

    // Register 0 never waits on an instruction
    a_no_owner_r0: assert property (@(posedge clock) disable iff (!rst_n) !owner_valid[0])
        else $error("scoreboard recorded an owner for register 0");

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_decode -o sim_tb_decode
out=$(./obj_dir/sim_tb_decode)
echo "$out"
if echo "$out" | grep -q "Test passed"; then
    exit 0
else
    exit 1
fi

/* tb.f */
logic/isa_pkg.sv
logic/decode_pkg.sv
logic/rf_write_if.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/scoreboard.sv
logic/decode_stage.sv
test/decode_checker.sv
test/tb_decode.sv

/* test/decode_checker.sv */
module decode_checker #(
    parameter int ROB_W = 4
)
(
    input  logic             clock,
    input  logic             rst_n,

    // DUT issue side
    input  logic [6:0]       issue_opcode,
    input  logic [4:0]       issue_rd,
    input  logic [31:0]      issue_pc,
    input  logic [ROB_W-1:0] issue_rob_id,
    input  logic [31:0]      issue_ra_data,
    input  logic [31:0]      issue_rb_data,
    input  logic [31:0]      issue_offset,
    input  logic [ROB_W-1:0] issue_ticket_src1,
    input  logic             issue_blocks_src1,
    input  logic [ROB_W-1:0] issue_ticket_src2,
    input  logic             issue_blocks_src2,
    input  logic             issue_illegal,
    input  logic             alu_valid,
    input  logic             alu_ready,
    input  logic             mul_valid,
    input  logic             mul_ready,

    // Expected record, pushed for one cycle
    input  logic             exp_push,
    input  logic [31:0]      exp_instr,
    input  logic [31:0]      exp_pc,
    input  logic             exp_unit,
    input  logic [31:0]      exp_ra_data,
    input  logic [31:0]      exp_rb_data,
    input  logic             exp_blocks1,
    input  logic [ROB_W-1:0] exp_ticket1,
    input  logic             exp_blocks2,
    input  logic [ROB_W-1:0] exp_ticket2,
    input  logic [ROB_W-1:0] exp_rob_id,
    input  logic             exp_illegal,

    output int               checked_count,
    output int               error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0]      instr;
        logic [31:0]      pc;
        logic             unit;
        logic [31:0]      ra_data;
        logic [31:0]      rb_data;
        logic             blocks1;
        logic [ROB_W-1:0] ticket1;
        logic             blocks2;
        logic [ROB_W-1:0] ticket2;
        logic [ROB_W-1:0] rob_id;
        logic             illegal;
    } expect_t;

    expect_t exp_q[$];

    initial
    begin
        checked_count = 0;
        error_count   = 0;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("MISMATCH test %0d %s expected %h actual %h",
                     checked_count, name, expected, actual);
            error_count++;
        end
    endtask

    ////////////////////
    // Compare on every issue handshake

    always @(posedge clock)
    begin
        expect_t e;
        int      errs_before;
        if (rst_n && ((alu_valid && alu_ready) || (mul_valid && mul_ready)))
        begin
            if (exp_q.size() == 0)
            begin
                $display("ERROR: instruction issued with no expected record waiting");
                error_count++;
            end
            else
            begin
                e = exp_q.pop_front();
                errs_before = error_count;
                if (mul_valid != e.unit)
                begin
                    $display("ERROR: test %0d issued on the wrong unit", checked_count);
                    error_count++;
                end
                // Opcode, rd and offset come straight from the instruction fields
                check_value("issue_opcode", 32'(e.instr[31:25]), 32'(issue_opcode));
                check_value("issue_rd", 32'(e.instr[24:20]), 32'(issue_rd));
                check_value("issue_offset", {17'b0, e.instr[14:0]}, issue_offset);
                check_value("issue_pc", e.pc, issue_pc);
                check_value("issue_rob_id", 32'(e.rob_id), 32'(issue_rob_id));
                check_value("issue_ra_data", e.ra_data, issue_ra_data);
                check_value("issue_rb_data", e.rb_data, issue_rb_data);
                check_value("issue_blocks_src1", 32'(e.blocks1), 32'(issue_blocks_src1));
                check_value("issue_blocks_src2", 32'(e.blocks2), 32'(issue_blocks_src2));
                // A ticket only means something while the source is owned
                if (e.blocks1)
                    check_value("issue_ticket_src1", 32'(e.ticket1), 32'(issue_ticket_src1));
                if (e.blocks2)
                    check_value("issue_ticket_src2", 32'(e.ticket2), 32'(issue_ticket_src2));
                check_value("issue_illegal", 32'(e.illegal), 32'(issue_illegal));
                if (error_count == errs_before)
                    $display("test %0d pc %h ok", checked_count, e.pc);
                else
                    $display("test %0d pc %h FAILED with %0d errors", checked_count, e.pc,
                             error_count - errs_before);
                checked_count++;
            end
        end
        if (rst_n && exp_push)
        begin
            exp_q.push_back({exp_instr, exp_pc, exp_unit, exp_ra_data, exp_rb_data,
                             exp_blocks1, exp_ticket1, exp_blocks2, exp_ticket2,
                             exp_rob_id, exp_illegal});
        end
    end

endmodule

/* test/decode_input.txt */
# W addr data rob_id, B is the same write held for the next instruction
# I instr pc hold unit ra_data rb_data blocks1 ticket1 blocks2 ticket2 rob_id illegal
W 1 0000000a 0
W 2 00000014 0
W 3 00000003 0
I 00408800 00000100 0 0 0000000a 00000014 0 0 0 0 0 0
I 06508c00 00000104 0 1 0000000a 00000003 0 0 0 0 1 0
I 02621400 00000108 3 0 00000000 00000000 1 0 1 1 2 0
W 4 00000064 5
I 04720400 0000010c 0 0 00000064 0000000a 1 0 0 0 3 0
W 4 00000064 0
I 08820123 00000110 0 0 00000064 00000000 0 0 0 0 4 0
B 5 00000007 1
I 00928000 00000114 0 0 00000007 00000000 0 0 0 0 5 0
I 0a108800 00000118 0 0 0000000a 00000014 0 0 0 0 6 1
I 22608008 0000011c 2 0 0000000a 00000000 0 0 1 2 7 0
I 06a10800 00000120 4 1 00000014 00000014 0 0 0 0 8 0
I 60051c00 00000124 0 0 00000000 00000000 1 8 1 3 9 0

/* test/tb_decode.sv */
module tb_decode;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROB_W = 4;

    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        logic [31:0] f6;
        logic [31:0] f7;
        logic [31:0] f8;
        logic [31:0] f9;
        logic [31:0] f10;
        logic [31:0] f11;
    } record_t;

    logic clock;
    logic rst_n;
    logic fetch_valid, fetch_ready;
    logic [31:0] fetch_instr, fetch_pc;
    logic wb_valid;
    logic [4:0] wb_addr;
    logic [31:0] wb_data;
    logic [ROB_W-1:0] wb_rob_id;
    logic [6:0] issue_opcode;
    logic [4:0] issue_rd;
    logic [31:0] issue_pc, issue_ra_data, issue_rb_data, issue_offset;
    logic [ROB_W-1:0] issue_rob_id, issue_ticket_src1, issue_ticket_src2;
    logic issue_blocks_src1, issue_blocks_src2, issue_illegal;
    logic alu_valid, alu_ready, mul_valid, mul_ready;

    logic exp_push, exp_unit, exp_blocks1, exp_blocks2, exp_illegal;
    logic [31:0] exp_instr, exp_pc, exp_ra_data, exp_rb_data;
    logic [ROB_W-1:0] exp_ticket1, exp_ticket2, exp_rob_id;
    int checked_count, error_count;

    record_t recs[$];
    int      hold_q[$];
    integer  seed = 32'h5dcbe459;
    int      cycle_count = 0;
    int      cycle_limit = 32'h7fff_ffff;
    int      instr_total = 0;
    int      cur_hold;
    logic    accepted;
    logic    file_missing;

    decode_stage #(.ROB_ID_WIDTH(ROB_W)) u_decode_stage (.*);

    decode_checker #(.ROB_W(ROB_W)) u_decode_checker (.*);

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // Reads every record so the cycle limit is known up front
    task automatic load_records(output int max_hold);
        int      fd;
        int      n;
        string   line;
        byte     ch;
        record_t r;
        max_hold = 0;
        fd = $fopen("test/decode_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open test/decode_input.txt");
            file_missing = 1'b1;
        end
        else
        begin
            while ($fscanf(fd, " %c", ch) == 1)
            begin
                r = '0;
                r.kind = ch;
                if (ch == "#")
                    n = $fgets(line, fd);
                else if (ch == "W" || ch == "B")
                begin
                    n = $fscanf(fd, "%h %h %h", r.f0, r.f1, r.f2);
                    recs.push_back(r);
                end
                else
                begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", r.f0, r.f1, r.f2,
                                r.f3, r.f4, r.f5, r.f6, r.f7, r.f8, r.f9, r.f10, r.f11);
                    recs.push_back(r);
                    instr_total++;
                    if (int'(r.f2) > max_hold)
                        max_hold = int'(r.f2);
                end
            end
            $fclose(fd);
        end
    endtask

    // One clock cycle from a falling edge to the next
    task automatic step_cycle();
        logic accept;
        logic drain;
        if ((alu_valid || mul_valid) && hold_q.size() > 0 && hold_q[0] > 0)
        begin
            alu_ready = 1'b0;
            mul_ready = 1'b0;
            hold_q[0] = hold_q[0] - 1;
        end
        else
        begin
            alu_ready = (($random(seed) & 3) != 0);
            mul_ready = (($random(seed) & 3) != 0);
        end
        #1;
        accept = fetch_valid && fetch_ready;
        drain  = (alu_valid && alu_ready) || (mul_valid && mul_ready);
        if (drain)
            void'(hold_q.pop_front());
        if (accept)
            hold_q.push_back(cur_hold);
        accepted = accept;
        @(negedge clock);
    endtask

    initial
    begin
        int max_hold;
        rst_n = 1'b0;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        fetch_pc = '0;
        wb_valid = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        wb_rob_id = '0;
        alu_ready = 1'b0;
        mul_ready = 1'b0;
        exp_push = 1'b0;
        {exp_instr, exp_pc, exp_unit, exp_ra_data, exp_rb_data} = '0;
        {exp_blocks1, exp_ticket1, exp_blocks2, exp_ticket2, exp_rob_id, exp_illegal} = '0;
        cur_hold = 0;
        accepted = 1'b0;
        file_missing = 1'b0;

        load_records(max_hold);
        cycle_limit = recs.size() * (max_hold + 4) + 50;

        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        ////////////////////
        // Drive the records

        foreach (recs[i])
        begin
            if (recs[i].kind == "W" || recs[i].kind == "B")
            begin
                wb_valid  = 1'b1;
                wb_addr   = recs[i].f0[4:0];
                wb_data   = recs[i].f1;
                wb_rob_id = recs[i].f2[ROB_W-1:0];
                // B stays up until the next instruction is accepted
                if (recs[i].kind == "W")
                begin
                    step_cycle();
                    wb_valid = 1'b0;
                end
            end
            else
            begin
                fetch_valid = 1'b1;
                fetch_instr = recs[i].f0;
                fetch_pc    = recs[i].f1;
                cur_hold    = int'(recs[i].f2);
                exp_push    = 1'b1;
                exp_instr   = recs[i].f0;
                exp_pc      = recs[i].f1;
                exp_unit    = recs[i].f3[0];
                exp_ra_data = recs[i].f4;
                exp_rb_data = recs[i].f5;
                exp_blocks1 = recs[i].f6[0];
                exp_ticket1 = recs[i].f7[ROB_W-1:0];
                exp_blocks2 = recs[i].f8[0];
                exp_ticket2 = recs[i].f9[ROB_W-1:0];
                exp_rob_id  = recs[i].f10[ROB_W-1:0];
                exp_illegal = recs[i].f11[0];
                step_cycle();
                exp_push = 1'b0;
                while (!accepted)
                    step_cycle();
                fetch_valid = 1'b0;
                wb_valid    = 1'b0;
            end
        end

        while (checked_count < instr_total)
            step_cycle();

        $display("%0d of %0d tests checked, %0d errors", checked_count, instr_total,
                 error_count);
        if (!file_missing && error_count == 0 && checked_count == instr_total)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
